// ==== common/mem_pkg.sv ====
// data memory access types: operation codes, request and load context structs
package mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int C_XLEN  = 64;
  localparam int C_LANES = C_XLEN / 8;
  // bits needed to name one byte lane inside a word
  localparam int C_OFF_W = $clog2(C_LANES);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory operation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the op selects the access size for both loads and stores,
  // the unsigned variants only matter on the load path
  typedef enum logic [2:0] {
    LB   = 3'd0,
    LBU  = 3'd1,
    LH   = 3'd2,
    LHU  = 3'd3,
    LW   = 3'd4,
    LWU  = 3'd5,
    LD   = 3'd6,
    NONE = 3'd7
  } mem_op_e;

  // one request per cycle from the core
  typedef struct packed {
    logic [C_XLEN-1:0] addr;
    logic [C_XLEN-1:0] wdata;
    mem_op_e           op;
    logic              we;
  } mem_req_t;

  // what the load path must remember across the ram read
  typedef struct packed {
    mem_op_e            op;
    logic [C_OFF_W-1:0] offset;
  } lane_ctx_t;

endpackage

// ==== filelist.f ====
+incdir+testbench
common/mem_pkg.sv
mem_access/access_lane_decode.sv
mem_access/data_ram_bank.sv
mem_access/load_lane_extract.sv
logic/mem_access_top.sv
testbench/tb_mem_access.sv

// ==== logic/mem_access_top.sv ====
// data memory access top: decode, ram bank and load extract in a one cycle pipeline
`timescale 1ns/1ps

module mem_access_top
  import mem_pkg::*;
#(
  parameter int P_DEPTH = 512
) (
  input  logic              i_rdclk,
  input  logic              i_rst,
  input  logic              i_req_valid,
  input  mem_req_t          i_req,
  output logic              o_rvalid,
  output logic [C_XLEN-1:0] o_rdata,
  output logic              o_misalign
);

  localparam int C_IDX_W = $clog2(P_DEPTH);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request side, same cycle as the request
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [C_IDX_W-1:0] dec_index;
  logic [C_LANES-1:0] dec_wmask;
  logic [C_XLEN-1:0]  dec_wdata;
  logic               dec_rd_en;
  lane_ctx_t          dec_ctx;

  // response side, one cycle later
  logic [C_XLEN-1:0]  ram_rword;
  lane_ctx_t          ram_ctx;
  logic               ram_rd_valid;

  access_lane_decode #(
    .P_DEPTH (P_DEPTH)
  ) i_access_lane_decode (
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_index     (dec_index),
    .o_wmask     (dec_wmask),
    .o_wdata     (dec_wdata),
    .o_rd_en     (dec_rd_en),
    .o_ctx       (dec_ctx),
    .o_misalign  (o_misalign)
  );

  data_ram_bank #(
    .P_DEPTH (P_DEPTH)
  ) i_data_ram_bank (
    .i_rdclk    (i_rdclk),
    .i_rst      (i_rst),
    .i_index    (dec_index),
    .i_wmask    (dec_wmask),
    .i_wdata    (dec_wdata),
    .i_rd_en    (dec_rd_en),
    .i_ctx      (dec_ctx),
    .o_rword    (ram_rword),
    .o_ctx      (ram_ctx),
    .o_rd_valid (ram_rd_valid)
  );

  load_lane_extract i_load_lane_extract (
    .i_rword    (ram_rword),
    .i_ctx      (ram_ctx),
    .i_rd_valid (ram_rd_valid),
    .o_rdata    (o_rdata),
    .o_rvalid   (o_rvalid)
  );

endmodule

// ==== mem_access/access_lane_decode.sv ====
// request decoder: word index, byte lane mask, lane placed store data, alignment check
`timescale 1ns/1ps

module access_lane_decode
  import mem_pkg::*;
#(
  parameter int  P_DEPTH = 512,
  localparam int C_IDX_W = $clog2(P_DEPTH)
) (
  input  logic               i_req_valid,
  input  mem_req_t           i_req,
  output logic [C_IDX_W-1:0] o_index,
  output logic [C_LANES-1:0] o_wmask,
  output logic [C_XLEN-1:0]  o_wdata,
  output logic               o_rd_en,
  output lane_ctx_t          o_ctx,
  output logic               o_misalign
);

  logic [C_OFF_W-1:0] offset;
  logic [C_OFF_W-1:0] align_bits;
  logic [C_LANES-1:0] base_mask;
  logic               is_access;
  logic               misalign;
  logic               go;

  assign offset    = i_req.addr[C_OFF_W-1:0];
  assign is_access = i_req_valid && (i_req.op != NONE);

  // size decode, the low address bits that must be zero for each size
  always_comb begin
    case (i_req.op)
      LB, LBU: begin
        base_mask  = 8'b0000_0001;
        align_bits = 3'b000;
      end
      LH, LHU: begin
        base_mask  = 8'b0000_0011;
        align_bits = 3'b001;
      end
      LW, LWU: begin
        base_mask  = 8'b0000_1111;
        align_bits = 3'b011;
      end
      LD: begin
        base_mask  = 8'b1111_1111;
        align_bits = 3'b111;
      end
      default: begin
        base_mask  = '0;
        align_bits = 3'b000;
      end
    endcase
  end

  assign misalign = is_access && ((offset & align_bits) != '0);
  assign go       = is_access && !misalign;

  // word index wraps modulo the ram depth
  assign o_index    = i_req.addr[C_OFF_W +: C_IDX_W];
  assign o_wmask    = (go && i_req.we) ? (base_mask << offset) : '0;
  assign o_wdata    = i_req.wdata << {offset, 3'b000};
  assign o_rd_en    = go && !i_req.we;
  assign o_ctx      = '{op: i_req.op, offset: offset};
  assign o_misalign = misalign;

endmodule

// ==== mem_access/data_ram_bank.sv ====
// data ram: byte masked synchronous write, registered read word and load context
`timescale 1ns/1ps

module data_ram_bank
  import mem_pkg::*;
#(
  parameter int  P_DEPTH = 512,
  localparam int C_IDX_W = $clog2(P_DEPTH)
) (
  input  logic               i_rdclk,
  input  logic               i_rst,
  input  logic [C_IDX_W-1:0] i_index,
  input  logic [C_LANES-1:0] i_wmask,
  input  logic [C_XLEN-1:0]  i_wdata,
  input  logic               i_rd_en,
  input  lane_ctx_t          i_ctx,
  output logic [C_XLEN-1:0]  o_rword,
  output lane_ctx_t          o_ctx,
  output logic               o_rd_valid
);

  logic [C_XLEN-1:0] mem [P_DEPTH];
  logic [C_XLEN-1:0] rword_q;
  lane_ctx_t         ctx_q;
  logic              rd_valid_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one enable per byte lane
  always_ff @(posedge i_rdclk) begin
    for (int b = 0; b < C_LANES; b++) begin
      if (i_wmask[b]) begin
        mem[i_index][b*8 +: 8] <= i_wdata[b*8 +: 8];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // word and context hold until the next load
  always_ff @(posedge i_rdclk) begin
    if (i_rd_en) begin
      rword_q <= mem[i_index];
      ctx_q   <= i_ctx;
    end
  end

  // single cycle pulse per accepted load
  always_ff @(posedge i_rdclk) begin
    if (!i_rst) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= i_rd_en;
    end
  end

  assign o_rword    = rword_q;
  assign o_ctx      = ctx_q;
  assign o_rd_valid = rd_valid_q;

  // decode never issues a load and a store in the same cycle
  a_no_rd_wr_overlap: assert property (
    @(posedge i_rdclk) disable iff (!i_rst)
    !(i_rd_en && (i_wmask != '0))
  );

  // a store mask covers 1, 2, 4 or 8 bytes at their natural alignment
  a_wmask_aligned: assert property (
    @(posedge i_rdclk) disable iff (!i_rst)
    (i_wmask != '0) |-> (i_wmask inside {
      8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80,
      8'h03, 8'h0c, 8'h30, 8'hc0,
      8'h0f, 8'hf0,
      8'hff
    })
  );

endmodule

// ==== mem_access/load_lane_extract.sv ====
// load extract: picks the addressed lane from the read word and sign or zero extends it
`timescale 1ns/1ps

module load_lane_extract
  import mem_pkg::*;
(
  input  logic [C_XLEN-1:0] i_rword,
  input  lane_ctx_t         i_ctx,
  input  logic              i_rd_valid,
  output logic [C_XLEN-1:0] o_rdata,
  output logic              o_rvalid
);

  logic [C_XLEN-1:0] shifted;

  // bring the addressed byte down to lane 0
  assign shifted = i_rword >> {i_ctx.offset, 3'b000};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // size and sign
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (i_ctx.op)
      LB: begin
        o_rdata = {{(C_XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      LBU: begin
        o_rdata = {{(C_XLEN-8){1'b0}}, shifted[7:0]};
      end
      LH: begin
        o_rdata = {{(C_XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      LHU: begin
        o_rdata = {{(C_XLEN-16){1'b0}}, shifted[15:0]};
      end
      LW: begin
        o_rdata = {{(C_XLEN-32){shifted[31]}}, shifted[31:0]};
      end
      LWU: begin
        o_rdata = {{(C_XLEN-32){1'b0}}, shifted[31:0]};
      end
      // LD is always aligned, so the shift is zero here
      default: begin
        o_rdata = shifted;
      end
    endcase
  end

  assign o_rvalid = i_rd_valid;

  // the ram only raises read valid for a context captured from a real load
  always_comb begin
    if (i_rd_valid) begin
      a_ctx_op_valid: assert #0 (i_ctx.op != NONE);
    end
  end

endmodule

// ==== testbench/tb_mem_model.svh ====
// testbench memory model: lfsr stimulus source, byte shadow of the ram, expected load values
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h1984;

// one entry per ram byte, plus a flag once the byte holds known data
logic [7:0]  shadow_mem     [C_MEM_BYTES];
bit          shadow_written [C_MEM_BYTES];

function automatic logic take_bit();
  logic fb;
  fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

// n fresh bits, one lfsr step each
function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[62:0], take_bit()};
  end
  return v;
endfunction

// access size in bytes, zero for no access
function automatic int op_size(input mem_op_e op);
  case (op)
    LB, LBU: return 1;
    LH, LHU: return 2;
    LW, LWU: return 4;
    LD:      return 8;
    default: return 0;
  endcase
endfunction

function automatic bit op_signed(input mem_op_e op);
  return (op == LB) || (op == LH) || (op == LW);
endfunction

function automatic bit bytes_written(input int size, input logic [63:0] addr);
  int base;
  base = int'(addr % C_MEM_BYTES);
  for (int b = 0; b < size; b++) begin
    if (!shadow_written[(base + b) % C_MEM_BYTES]) begin
      return 1'b0;
    end
  end
  return 1'b1;
endfunction

// little endian, low bytes of the store data go to the lowest address
function automatic void shadow_store(input int size, input logic [63:0] addr,
                                     input logic [63:0] data);
  int base;
  base = int'(addr % C_MEM_BYTES);
  for (int b = 0; b < size; b++) begin
    shadow_mem[(base + b) % C_MEM_BYTES]     = data[b*8 +: 8];
    shadow_written[(base + b) % C_MEM_BYTES] = 1'b1;
  end
endfunction

function automatic logic [63:0] expected_load(input mem_op_e op, input logic [63:0] addr);
  int          size;
  int          base;
  logic [63:0] raw;
  size = op_size(op);
  base = int'(addr % C_MEM_BYTES);
  raw  = '0;
  for (int b = size - 1; b >= 0; b--) begin
    raw = {raw[55:0], shadow_mem[(base + b) % C_MEM_BYTES]};
  end
  // fill everything above the loaded bytes with the top data bit
  if (op_signed(op) && raw[size*8-1]) begin
    raw = raw | ({64{1'b1}} << (size * 8));
  end
  return raw;
endfunction

`endif

// ==== testbench/tb_mem_access.sv ====
// testbench for the data memory access block with directed and random load and store traffic
`timescale 1ns/1ps

module tb_mem_access
  import mem_pkg::*;
();

  localparam int C_DEPTH         = 16;
  localparam int C_MEM_BYTES     = C_DEPTH * C_LANES;
  localparam int C_DIRECTED_REQS = 29;
  localparam int C_RAND_REQS     = 300;
  localparam int C_CYCLE_LIMIT   = 2 * (C_DIRECTED_REQS + C_RAND_REQS) + 50;

  `include "tb_mem_model.svh"

  logic              rdclk;
  logic              rst;
  logic              req_valid;
  mem_req_t          req;
  logic              rvalid;
  logic [C_XLEN-1:0] rdata;
  logic              misalign;

  // expectation for the request on the inputs, and the one for the response now out
  logic              req_exp_valid;
  logic [C_XLEN-1:0] req_exp_data;
  logic              req_exp_misalign;
  logic              exp_valid_q;
  logic [C_XLEN-1:0] exp_data_q;

  int error_count   = 0;
  int request_count = 0;
  int load_count    = 0;
  int cycle_count   = 0;

  mem_access_top #(
    .P_DEPTH (C_DEPTH)
  ) i_mem_access_top (
    .i_rdclk     (rdclk),
    .i_rst       (rst),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_rvalid    (rvalid),
    .o_rdata     (rdata),
    .o_misalign  (misalign)
  );

  always #5 rdclk = ~rdclk;

  always @(posedge rdclk) begin
    if (!rst) begin
      exp_valid_q <= 1'b0;
    end else begin
      exp_valid_q <= req_exp_valid;
      exp_data_q  <= req_exp_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_rvalid_low_after_reset: assert property (@(posedge rdclk) $rose(rst) |-> !rvalid)
    else begin
      error_count++;
      $display("Fail at time %0t: o_rvalid high right after reset", $time);
    end

  a_rvalid_match: assert property (@(posedge rdclk) disable iff (!rst) rvalid == exp_valid_q)
    else begin
      error_count++;
      $display("Fail at time %0t: o_rvalid %0b, expected %0b",
               $time, $sampled(rvalid), $sampled(exp_valid_q));
    end

  a_rdata_match: assert property (
    @(posedge rdclk) disable iff (!rst) exp_valid_q |-> (rdata == exp_data_q)
  ) else begin
    error_count++;
    $display("Fail at time %0t: o_rdata %h, expected %h",
             $time, $sampled(rdata), $sampled(exp_data_q));
  end

  // misalign is combinational, so it is judged in the request cycle itself
  a_misalign_match: assert property (
    @(posedge rdclk) disable iff (!rst) misalign == req_exp_misalign
  ) else begin
    error_count++;
    $display("Fail at time %0t: o_misalign %0b, expected %0b",
             $time, $sampled(misalign), $sampled(req_exp_misalign));
  end

  always @(posedge rdclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= C_CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", C_CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  // one request per cycle with expectations and shadow kept in step
  task automatic issue_request(input logic valid, input mem_op_e op, input logic we,
                               input logic [63:0] addr, input logic [63:0] wdata);
    int   size;
    logic access;
    logic mis;
    size   = op_size(op);
    access = valid && (op != NONE);
    mis    = 1'b0;
    if (access) begin
      mis = (addr % size) != 0;
    end
    req_exp_misalign = mis;
    req_exp_valid    = access && !mis && !we;
    req_exp_data     = '0;
    if (req_exp_valid) begin
      req_exp_data = expected_load(op, addr);
      load_count++;
    end
    if (access && !mis && we) begin
      shadow_store(size, addr, wdata);
    end
    req_valid = valid;
    req.addr  = addr;
    req.wdata = wdata;
    req.op    = op;
    req.we    = we;
    request_count++;
    @(posedge rdclk);
    #1;
  endtask

  initial begin
    mem_op_e     ops [7];
    int          offs [7];
    mem_op_e     op;
    logic        we;
    logic [63:0] addr;
    logic [63:0] data;
    logic        keep_raw;
    int          size;
    ops  = '{LB, LBU, LH, LHU, LW, LWU, LD};
    offs = '{3, 5, 2, 6, 4, 0, 0};
    rdclk            = 1'b0;
    rst              = 1'b0;
    // a load held on the bus during reset must not show up as o_rvalid afterwards
    req_valid        = 1'b1;
    req              = '{addr: '0, wdata: '0, op: LD, we: 1'b0};
    req_exp_valid    = 1'b0;
    req_exp_data     = '0;
    req_exp_misalign = 1'b0;
    repeat (4) @(posedge rdclk);
    #1;
    rst = 1'b1;

    // store then load each size with data whose top bit of every size is set
    for (int k = 0; k < 7; k++) begin
      issue_request(1'b1, ops[k], 1'b1, 8 * k + offs[k], 64'h89ab_cdef_f1e2_d3c4);
      issue_request(1'b1, ops[k], 1'b0, 8 * k + offs[k], '0);
    end

    // narrow stores into a full word leave the other lanes alone
    issue_request(1'b1, LD, 1'b1, 64, 64'h0011_2233_4455_6677);
    issue_request(1'b1, LB, 1'b1, 69, 64'h9a);
    issue_request(1'b1, LH, 1'b1, 66, 64'hbeef);
    issue_request(1'b1, LD, 1'b0, 64, '0);

    // misaligned stores and loads then an aligned load of the untouched word
    issue_request(1'b1, LH, 1'b1, 65, 64'hffff);
    issue_request(1'b1, LW, 1'b1, 66, 64'hffff_ffff);
    issue_request(1'b1, LD, 1'b1, 68, 64'hffff_ffff_ffff_ffff);
    issue_request(1'b1, LD, 1'b0, 67, '0);
    issue_request(1'b1, LHU, 1'b0, 71, '0);
    issue_request(1'b1, LD, 1'b0, 64, '0);

    // no-op and idle cycles
    issue_request(1'b1, NONE, 1'b1, 67, 64'h5555_5555_5555_5555);
    issue_request(1'b1, NONE, 1'b0, 69, '0);
    issue_request(1'b0, LD, 1'b1, 64, 64'haaaa_aaaa_aaaa_aaaa);
    issue_request(1'b0, LH, 1'b0, 65, '0);
    issue_request(1'b1, LD, 1'b0, 64, '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random back to back traffic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (int n = 0; n < C_RAND_REQS; n++) begin
      op       = mem_op_e'(3'(rand_bits(3)));
      we       = take_bit();
      addr     = rand_bits(7);
      keep_raw = rand_bits(3) == 0;
      data     = rand_bits(64);
      size     = op_size(op);
      // about one in eight keeps its raw, possibly misaligned, address
      if (size != 0 && !keep_raw) begin
        addr = addr - (addr % size);
      end
      // a load of unknown bytes turns into a store
      if (!we && size != 0 && (addr % size) == 0 && !bytes_written(size, addr)) begin
        we = 1'b1;
      end
      issue_request(1'b1, op, we, addr, data);
    end

    req_valid        = 1'b0;
    req_exp_valid    = 1'b0;
    req_exp_misalign = 1'b0;
    repeat (2) @(posedge rdclk);
    #1;
    $display("requests %0d, loads checked %0d, errors %0d",
             request_count, load_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
